//--- Makefile
# Verilator build and run for the elk_system testbench

VERILATOR ?= verilator
TOP       ?= tb_elk_system
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	else \
		echo "run passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- files.f
source/elk_mem_pkg.sv
source/elk_host_pkg.sv
source/elk_bank_decode.sv
source/elk_memory.sv
source/elk_tape_slicer.sv
source/elk_apb_regs.sv
source/elk_system.sv
tests/elk_system_assert.sv
tests/tb_elk_system.sv

//--- source/elk_apb_regs.sv
// APB register block for the host ROM loader and tape status
// zero wait states, pslverr on bad offset or write while not loading
`default_nettype none

module elk_apb_regs (
	input  logic                       clk_sys,
	input  logic                       i_reset,
	input  elk_host_pkg::apb_req_t     i_apb,
	output elk_host_pkg::apb_rsp_t     o_apb,
	input  elk_host_pkg::tape_status_t i_status,
	output elk_host_pkg::rom_load_t    o_load
);

	import elk_mem_pkg::*;
	import elk_host_pkg::*;

	logic                  access;
	logic                  addr_ok;
	logic                  err;
	logic                  wr_ok;
	logic                  data_wr;
	logic                  load;
	logic [ROM_ADDR_W-1:0] rom_addr;
	logic [31:0]           rdata;

	assign access = i_apb.psel && i_apb.penable;

	//////////////////////////////////////////////////////////////////////
	// offset decode and read mux
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		addr_ok = 1'b1;
		rdata = '0;
		case (i_apb.paddr)
			REG_CTRL:     rdata = {31'b0, load};
			REG_ROM_ADDR: rdata = 32'(rom_addr);
			// write-only data port
			REG_ROM_DATA: rdata = '0;
			REG_STATUS:   rdata = 32'(i_status);
			default:      addr_ok = 1'b0;
		endcase
	end

	// data writes only while load is set
	assign err = !addr_ok || (i_apb.pwrite && i_apb.paddr == REG_ROM_DATA && !load);
	assign wr_ok = access && i_apb.pwrite && !err;
	assign data_wr = wr_ok && i_apb.paddr == REG_ROM_DATA;

	always_ff @(posedge clk_sys) begin
		if (i_reset) begin
			load <= 1'b0;
			rom_addr <= '0;
		end else if (wr_ok) begin
			case (i_apb.paddr)
				REG_CTRL:     load <= i_apb.pwdata[0];
				REG_ROM_ADDR: rom_addr <= i_apb.pwdata[ROM_ADDR_W-1:0];
				// byte goes out this cycle, then step
				REG_ROM_DATA: rom_addr <= rom_addr + 1'b1;
				default:      load <= load;
			endcase
		end
	end

	assign o_apb.prdata = rdata;
	assign o_apb.pready = access;
	assign o_apb.pslverr = access && err;

	// rom write during the access phase
	assign o_load.en = load;
	assign o_load.we = data_wr;
	assign o_load.addr = rom_addr;
	assign o_load.data = i_apb.pwdata[7:0];

endmodule

`default_nettype wire

//--- source/elk_bank_decode.sv
// sideways bank decoder
// maps the upper CPU address bits to a ROM bank, a RAM bank or nothing
`default_nettype none

module elk_bank_decode (
	input  elk_mem_pkg::mem_addr_u i_addr,
	output elk_mem_pkg::bank_sel_t o_sel
);

	import elk_mem_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// rom map
	// 01_00       -> bank 0
	// 10_00,10_01 -> bank 1 (aliased)
	// 10_10,10_11 -> bank 2 (aliased)
	// 11_xx       -> banks 3..6
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// default unmapped, reads as zero
		o_sel = '0;
		if (!i_addr.rom_view.ram_sel) begin
			case ({i_addr.rom_view.group, i_addr.rom_view.slot})
				4'b01_00: begin
					o_sel.rom_hit = 1'b1;
					o_sel.bank = 3'd0;
				end
				4'b10_00, 4'b10_01: begin
					o_sel.rom_hit = 1'b1;
					o_sel.bank = 3'd1;
				end
				4'b10_10, 4'b10_11: begin
					o_sel.rom_hit = 1'b1;
					o_sel.bank = 3'd2;
				end
				4'b11_00, 4'b11_01, 4'b11_10, 4'b11_11: begin
					o_sel.rom_hit = 1'b1;
					// slot 0..3 onto banks 3..6
					o_sel.bank = 3'd3 + {1'b0, i_addr.rom_view.slot};
				end
				default: begin
					// group 00 and 01 slots 01..11 stay empty
					o_sel.rom_hit = 1'b0;
				end
			endcase
		end else if (!i_addr.ram_view.high) begin
			// ram: bank field used as is
			o_sel.ram_hit = 1'b1;
			o_sel.bank = i_addr.ram_view.bank;
		end
		// ram_sel with high set falls through as unmapped
	end

endmodule

`default_nettype wire

//--- source/elk_host_pkg.sv
// host side definitions: APB words, register map,
// ROM loader word and ADC sample / tape status words
`default_nettype none

package elk_host_pkg;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [11:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// register offsets
	localparam logic [11:0] REG_CTRL     = 12'h000;
	localparam logic [11:0] REG_ROM_ADDR = 12'h004;
	localparam logic [11:0] REG_ROM_DATA = 12'h008;
	localparam logic [11:0] REG_STATUS   = 12'h00C;

	// one rom write per cycle with we high
	typedef struct packed {
		logic                               en;
		logic                               we;
		logic [elk_mem_pkg::ROM_ADDR_W-1:0] addr;
		logic [7:0]                         data;
	} rom_load_t;

	localparam int SAMPLE_W = 12;

	typedef struct packed {
		logic                valid;
		logic [SAMPLE_W-1:0] sample;
	} adc_sample_t;

	// tape_bit lands in bit 12 of STATUS
	typedef struct packed {
		logic                tape_bit;
		logic [SAMPLE_W-1:0] avg;
	} tape_status_t;

endpackage

`default_nettype wire

//--- source/elk_mem_pkg.sv
// memory map definitions for the sideways ROM/RAM section
// CPU bus word, address views and bank select word
`default_nettype none

package elk_mem_pkg;

	// offset inside one 16 KiB bank
	localparam int OFFSET_W = 14;
	// CPU address width
	localparam int ADDR_W = 19;

	localparam int ROM_BANKS = 7;
	localparam int RAM_BANKS = 8;

	// linear array indices
	localparam int ROM_ADDR_W = 17;
	localparam int RAM_ADDR_W = 17;

	// rom side: ram_sel clear, group and slot pick a bank
	typedef struct packed {
		logic                ram_sel;
		logic [1:0]          group;
		logic [1:0]          slot;
		logic [OFFSET_W-1:0] offset;
	} rom_view_t;

	// ram side: ram_sel set, high clear, bank field takes the rest
	typedef struct packed {
		logic                         ram_sel;
		logic                         high;
		logic [ADDR_W-OFFSET_W-3:0]   bank;
		logic [OFFSET_W-1:0]          offset;
	} ram_view_t;

	// same 19-bit word, read as rom or ram layout
	typedef union packed {
		rom_view_t rom_view;
		ram_view_t ram_view;
	} mem_addr_u;

	// cpu strobe bus, we_n low while writing
	typedef struct packed {
		mem_addr_u  addr;
		logic       we_n;
		logic [7:0] wdata;
	} cpu_bus_t;

	typedef struct packed {
		logic       rom_hit;
		logic       ram_hit;
		logic [2:0] bank;
	} bank_sel_t;

endpackage

`default_nettype wire

//--- source/elk_memory.sv
// ROM and RAM arrays behind the bank decoder
// loader writes into ROM, CPU writes RAM once per we_n falling edge,
// read data arrives one cycle after the address
`default_nettype none

module elk_memory (
	input  logic                    clk_sys,
	input  logic                    i_reset,
	input  elk_mem_pkg::cpu_bus_t   i_cpu,
	input  elk_mem_pkg::bank_sel_t  i_sel,
	input  elk_host_pkg::rom_load_t i_load,
	output logic [7:0]              o_rdata
);

	import elk_mem_pkg::*;

	localparam int ROM_DEPTH = ROM_BANKS << OFFSET_W;
	localparam int RAM_DEPTH = RAM_BANKS << OFFSET_W;

	logic [7:0] rom [ROM_DEPTH];
	logic [7:0] ram [RAM_DEPTH];

	logic [ROM_ADDR_W-1:0] rom_addr;
	logic [RAM_ADDR_W-1:0] ram_addr;
	logic                  rom_we;
	logic                  ram_we;
	logic                  we_n_q;
	logic [7:0]            rom_q;
	logic [7:0]            ram_q;
	logic                  rom_hit_q;
	logic                  ram_hit_q;

	//////////////////////////////////////////////////////////////////////
	// address and write enables
	//////////////////////////////////////////////////////////////////////

	// loader owns the rom port while load is set
	assign rom_addr = i_load.en ? i_load.addr : {i_sel.bank, i_cpu.addr.rom_view.offset};
	assign ram_addr = {i_sel.bank, i_cpu.addr.ram_view.offset};

	// drop loader writes past the last bank
	assign rom_we = i_load.en && i_load.we && (rom_addr < ROM_ADDR_W'(ROM_DEPTH));

	// first low cycle of we_n, mapped ram only
	assign ram_we = i_sel.ram_hit && we_n_q && !i_cpu.we_n;

	always_ff @(posedge clk_sys) begin
		if (i_reset) begin
			we_n_q <= 1'b1;
			rom_hit_q <= 1'b0;
			ram_hit_q <= 1'b0;
		end else begin
			we_n_q <= i_cpu.we_n;
			rom_hit_q <= i_sel.rom_hit;
			ram_hit_q <= i_sel.ram_hit;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// arrays
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rom_we) begin
			rom[rom_addr] <= i_load.data;
		end
		rom_q <= rom[rom_addr];
	end

	// read before write on the same address
	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			ram[ram_addr] <= i_cpu.wdata;
		end
		ram_q <= ram[ram_addr];
	end

	// registered hits pick the source, unmapped reads zero
	always_comb begin
		if (rom_hit_q) begin
			o_rdata = rom_q;
		end else if (ram_hit_q) begin
			o_rdata = ram_q;
		end else begin
			o_rdata = 8'h00;
		end
	end

endmodule

`default_nettype wire

//--- source/elk_system.sv
// memory and tape-input subsystem
// bank decode, ROM/RAM arrays, tape slicer and host APB registers
`default_nettype none

module elk_system #(
	parameter int          AVG_LOG2   = 9,
	parameter int unsigned HYSTERESIS = 100
) (
	input  logic                      clk_sys,
	input  logic                      i_reset,
	input  elk_mem_pkg::cpu_bus_t     i_cpu,
	output logic [7:0]                o_cpu_rdata,
	input  elk_host_pkg::apb_req_t    i_apb,
	output elk_host_pkg::apb_rsp_t    o_apb,
	input  elk_host_pkg::adc_sample_t i_adc,
	output logic                      o_tape_bit
);

	import elk_mem_pkg::*;
	import elk_host_pkg::*;

	bank_sel_t    sel;
	rom_load_t    load;
	tape_status_t status;

	//////////////////////////////////////////////////////////////////////
	// cpu memory path
	//////////////////////////////////////////////////////////////////////

	elk_bank_decode u_bank_decode (
		.i_addr (i_cpu.addr),
		.o_sel  (sel)
	);

	elk_memory u_memory (
		.clk_sys (clk_sys),
		.i_reset (i_reset),
		.i_cpu   (i_cpu),
		.i_sel   (sel),
		.i_load  (load),
		.o_rdata (o_cpu_rdata)
	);

	//////////////////////////////////////////////////////////////////////
	// tape input and host registers
	//////////////////////////////////////////////////////////////////////

	elk_tape_slicer #(
		.AVG_LOG2   (AVG_LOG2),
		.HYSTERESIS (HYSTERESIS)
	) u_tape_slicer (
		.clk_sys  (clk_sys),
		.i_reset  (i_reset),
		.i_adc    (i_adc),
		.o_status (status)
	);

	elk_apb_regs u_apb_regs (
		.clk_sys  (clk_sys),
		.i_reset  (i_reset),
		.i_apb    (i_apb),
		.o_apb    (o_apb),
		.i_status (status),
		.o_load   (load)
	);

	assign o_tape_bit = status.tape_bit;

endmodule

`default_nettype wire

//--- source/elk_tape_slicer.sv
// cassette slicer for ADC samples
// running average over 2^AVG_LOG2 samples, tape bit with hysteresis band
`default_nettype none

module elk_tape_slicer #(
	parameter int          AVG_LOG2   = 9,
	parameter int unsigned HYSTERESIS = 100
) (
	input  logic                       clk_sys,
	input  logic                       i_reset,
	input  elk_host_pkg::adc_sample_t  i_adc,
	output elk_host_pkg::tape_status_t o_status
);

	import elk_host_pkg::*;

	localparam int DEPTH   = 1 << AVG_LOG2;
	localparam int TOTAL_W = SAMPLE_W + AVG_LOG2;

	logic [SAMPLE_W-1:0] window [DEPTH];
	logic [AVG_LOG2-1:0] wr_ptr;
	// set once the pointer has gone round
	logic                wrapped;
	logic [TOTAL_W-1:0]  total;
	logic [SAMPLE_W-1:0] oldest;
	logic [SAMPLE_W-1:0] old_avg;
	logic                below;
	logic                above;
	logic                tape_bit;

	// unwritten slots count as zero
	assign oldest = wrapped ? window[wr_ptr] : '0;

	// average before this sample
	assign old_avg = total[TOTAL_W-1:AVG_LOG2];

	// 32-bit compare, no wrap at either end of the range
	assign below = (32'(i_adc.sample) + 32'(HYSTERESIS)) < 32'(old_avg);
	assign above = 32'(i_adc.sample) > (32'(old_avg) + 32'(HYSTERESIS));

	//////////////////////////////////////////////////////////////////////
	// window and running total
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (i_adc.valid) begin
			window[wr_ptr] <= i_adc.sample;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (i_reset) begin
			wr_ptr <= '0;
			wrapped <= 1'b0;
			total <= '0;
			tape_bit <= 1'b0;
		end else if (i_adc.valid) begin
			wr_ptr <= wr_ptr + 1'b1;
			if (&wr_ptr) begin
				wrapped <= 1'b1;
			end
			// add newest, drop oldest
			total <= total + TOTAL_W'(i_adc.sample) - TOTAL_W'(oldest);
			// low level reads as a 1, inside the band holds
			if (below) begin
				tape_bit <= 1'b1;
			end else if (above) begin
				tape_bit <= 1'b0;
			end
		end
	end

	assign o_status.tape_bit = tape_bit;
	assign o_status.avg = total[TOTAL_W-1:AVG_LOG2];

endmodule

`default_nettype wire

//--- tests/elk_system_assert.sv
// APB protocol and reset checks for elk_system
// bound into the top level
`default_nettype none

module elk_system_assert (
	input logic                   clk_sys,
	input logic                   i_reset,
	input elk_host_pkg::apb_req_t i_apb,
	input elk_host_pkg::apb_rsp_t o_apb,
	input logic                   o_tape_bit
);

	timeunit 1ns;
	timeprecision 1ps;

	// zero wait states
	a_pready: assert property (@(posedge clk_sys) disable iff (i_reset)
		(i_apb.psel && i_apb.penable) |-> o_apb.pready)
		else $error("pready low during an APB access phase");

	// error only while a transfer completes
	a_slverr: assert property (@(posedge clk_sys) disable iff (i_reset)
		!(i_apb.psel && i_apb.penable) |-> !o_apb.pslverr)
		else $error("pslverr high outside an APB access phase");

	a_tape_reset: assert property (@(posedge clk_sys) i_reset |=> !o_tape_bit)
		else $error("tape bit not cleared after reset");

endmodule

bind elk_system elk_system_assert u_system_assert (
	.clk_sys    (clk_sys),
	.i_reset    (i_reset),
	.i_apb      (i_apb),
	.o_apb      (o_apb),
	.o_tape_bit (o_tape_bit)
);

`default_nettype wire

//--- tests/tb_elk_system.sv
// testbench for the elk_system memory and tape-input subsystem
// loads ROM over APB, exercises the bank map and RAM writes,
// then checks the tape slicer against a reference model
`default_nettype none

module tb_elk_system;

	timeunit 1ns;
	timeprecision 1ps;

	import elk_mem_pkg::*;
	import elk_host_pkg::*;

	localparam int TB_AVG_LOG2 = 4;
	localparam int TB_HYST = 100;
	localparam int WIN = 1 << TB_AVG_LOG2;
	localparam int ROM_N = 32;
	localparam int RAM_N = 6;
	localparam int TIMEOUT = 50;

	logic         clk_sys;
	logic         i_reset;
	cpu_bus_t     cpu_in;
	logic [7:0]   cpu_rdata;
	apb_req_t     apb_in;
	apb_rsp_t     apb_rsp;
	adc_sample_t  adc_in;
	logic         tape_bit;

	integer       seed;

	// shadow memories
	logic [7:0]   rom_sh [ROM_BANKS << OFFSET_W];
	logic [7:0]   ram_sh [RAM_BANKS << OFFSET_W];
	logic [13:0]  rom_base [ROM_BANKS];
	logic [18:0]  ram_list [$];

	// read handoff to the compare process
	logic         rd_pend;
	logic [7:0]   rd_exp;
	logic [18:0]  rd_addr;

	// slicer model state
	logic [11:0]  win_m [WIN];
	logic [TB_AVG_LOG2-1:0] ptr_m;
	int           total_m;
	logic         bit_m;

	elk_system #(
		.AVG_LOG2   (TB_AVG_LOG2),
		.HYSTERESIS (TB_HYST)
	) i_elk_system (
		.clk_sys     (clk_sys),
		.i_reset     (i_reset),
		.i_cpu       (cpu_in),
		.o_cpu_rdata (cpu_rdata),
		.i_apb       (apb_in),
		.o_apb       (apb_rsp),
		.i_adc       (adc_in),
		.o_tape_bit  (tape_bit)
	);

	initial begin : clock_gen
		clk_sys = 1'b0;
		forever begin
			#10 clk_sys = ~clk_sys;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// failure reporting and checks
	//////////////////////////////////////////////////////////////////////

	task automatic fail_stop();
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
			fail_stop();
		end
	endtask

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// reference models
	//////////////////////////////////////////////////////////////////////

	// rom bank for a group/slot pair, -1 when empty
	function automatic int rom_bank_of(input logic [1:0] grp, input logic [1:0] slot);
		if (grp == 2'b01 && slot == 2'b00) begin
			return 0;
		end
		if (grp == 2'b10) begin
			// two slots share each bank
			return slot[1] ? 2 : 1;
		end
		if (grp == 2'b11) begin
			return 3 + int'(slot);
		end
		return -1;
	endfunction

	// expected cpu byte for an address
	function automatic logic [7:0] ref_read(input logic [18:0] a);
		int bank;
		logic [16:0] idx;
		if (a[18]) begin
			// upper half of ram space is empty
			if (a[17]) begin
				return 8'h00;
			end
			idx = a[16:0];
			return ram_sh[idx];
		end
		bank = rom_bank_of(a[17:16], a[15:14]);
		if (bank < 0) begin
			return 8'h00;
		end
		idx = 17'(bank * 16384) + 17'(a[13:0]);
		return rom_sh[idx];
	endfunction

	// one valid sample into the model, returns {bit, avg}
	function automatic logic [12:0] slicer_ref(input logic [11:0] s);
		int old_avg;
		int smp;
		smp = int'(s);
		old_avg = total_m >> TB_AVG_LOG2;
		if (smp + TB_HYST < old_avg) begin
			bit_m = 1'b1;
		end else if (smp > old_avg + TB_HYST) begin
			bit_m = 1'b0;
		end
		total_m = total_m - int'(win_m[ptr_m]) + smp;
		win_m[ptr_m] = s;
		ptr_m = ptr_m + 1'b1;
		return {bit_m, 12'(total_m >> TB_AVG_LOG2)};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// bus tasks
	//////////////////////////////////////////////////////////////////////

	task automatic apb_access(input logic wr, input logic [11:0] addr,
			input logic [31:0] wdata, input logic exp_err, output logic [31:0] rdata);
		int n;
		@(posedge clk_sys);
		#2;
		apb_in.psel = 1'b1;
		apb_in.penable = 1'b0;
		apb_in.pwrite = wr;
		apb_in.paddr = addr;
		apb_in.pwdata = wdata;
		@(posedge clk_sys);
		#2;
		apb_in.penable = 1'b1;
		n = 0;
		@(negedge clk_sys);
		while (!apb_rsp.pready) begin
			if (n == TIMEOUT) begin
				$display("timeout: APB access phase never saw pready");
				fail_stop();
			end
			n++;
			@(negedge clk_sys);
		end
		rdata = apb_rsp.prdata;
		check($sformatf("pslverr @%03h", addr), 32'(apb_rsp.pslverr), 32'(exp_err));
		@(posedge clk_sys);
		#2;
		apb_in.psel = 1'b0;
		apb_in.penable = 1'b0;
	endtask

	task automatic cpu_read(input logic [18:0] a);
		@(posedge clk_sys);
		#2;
		cpu_in.addr = a;
		cpu_in.we_n = 1'b1;
		rd_addr = a;
		rd_exp = ref_read(a);
		rd_pend = 1'b1;
	endtask

	task automatic cpu_idle();
		@(posedge clk_sys);
		#2;
		rd_pend = 1'b0;
	endtask

	// we_n held low two cycles, data changes in the second
	task automatic cpu_write(input logic [18:0] a, input logic [7:0] d);
		logic [31:0] r;
		@(posedge clk_sys);
		#2;
		rd_pend = 1'b0;
		cpu_in.addr = a;
		cpu_in.we_n = 1'b0;
		cpu_in.wdata = d;
		@(posedge clk_sys);
		#2;
		r = rand_word();
		cpu_in.wdata = d ^ (r[7:0] | 8'h01);
		@(posedge clk_sys);
		#2;
		cpu_in.we_n = 1'b1;
		// only mapped ram banks take the byte
		if (a[18] && !a[17]) begin
			ram_sh[a[16:0]] = d;
		end
	endtask

	// read data lands one cycle after the address
	initial begin : compare_reads
		logic [7:0]  exp_q;
		logic [18:0] addr_q;
		forever begin
			@(posedge clk_sys);
			if (rd_pend) begin
				exp_q = rd_exp;
				addr_q = rd_addr;
				@(negedge clk_sys);
				check($sformatf("o_cpu_rdata @%05h", addr_q), 32'(cpu_rdata), 32'(exp_q));
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin : main_seq
		logic [31:0] rd;
		logic [31:0] r;
		logic [18:0] a;
		logic [16:0] start;
		logic [3:0]  cd;
		logic [13:0] off;
		logic [11:0] smp;
		logic [12:0] exp_st;
		int          bank;
		int          pick;
		seed = 32'hbc319b96;
		i_reset = 1'b1;
		cpu_in = '0;
		cpu_in.we_n = 1'b1;
		apb_in = '0;
		adc_in = '0;
		rd_pend = 1'b0;
		rd_exp = 8'h00;
		rd_addr = '0;
		total_m = 0;
		bit_m = 1'b0;
		ptr_m = '0;
		for (int k = 0; k < WIN; k++) begin
			win_m[TB_AVG_LOG2'(k)] = 12'h000;
		end
		repeat (16) @(posedge clk_sys);
		#2;
		i_reset = 1'b0;

		// status clear out of reset
		apb_access(1'b0, REG_STATUS, 32'h0, 1'b0, rd);
		check("STATUS after reset", rd, 32'h0);

		// rom load, one burst per bank
		apb_access(1'b1, REG_CTRL, 32'h1, 1'b0, rd);
		for (int b = 0; b < ROM_BANKS; b++) begin
			r = rand_word();
			rom_base[3'(b)] = r[13:0] & 14'h3fe0;
			start = 17'(b * 16384) + 17'(rom_base[3'(b)]);
			apb_access(1'b1, REG_ROM_ADDR, 32'(start), 1'b0, rd);
			apb_access(1'b0, REG_ROM_ADDR, 32'h0, 1'b0, rd);
			check("ROM_ADDR", rd, 32'(start));
			for (int i = 0; i < ROM_N; i++) begin
				r = rand_word();
				apb_access(1'b1, REG_ROM_DATA, r, 1'b0, rd);
				rom_sh[start + 17'(i)] = r[7:0];
			end
			apb_access(1'b0, REG_ROM_ADDR, 32'h0, 1'b0, rd);
			check("ROM_ADDR after increments", rd, 32'(start + 17'(ROM_N)));
		end
		apb_access(1'b1, REG_CTRL, 32'h0, 1'b0, rd);
		apb_access(1'b0, REG_CTRL, 32'h0, 1'b0, rd);
		check("CTRL", rd, 32'h0);

		// every rom region, aliased slots included, empty ones read zero
		for (int c = 0; c < 16; c++) begin
			cd = 4'(c);
			bank = rom_bank_of(cd[3:2], cd[1:0]);
			if (bank >= 0) begin
				for (int i = 0; i < ROM_N; i++) begin
					off = rom_base[3'(bank)] + 14'(i);
					cpu_read({1'b0, cd, off});
				end
			end else begin
				for (int i = 0; i < 4; i++) begin
					r = rand_word();
					cpu_read({1'b0, cd, r[13:0]});
				end
			end
		end
		cpu_idle();

		// data write refused while load is clear
		start = 17'(rom_base[0]);
		apb_access(1'b1, REG_ROM_ADDR, 32'(start), 1'b0, rd);
		apb_access(1'b1, REG_ROM_DATA, {24'h0, ~rom_sh[start]}, 1'b1, rd);
		apb_access(1'b0, REG_ROM_ADDR, 32'h0, 1'b0, rd);
		check("ROM_ADDR after refused write", rd, 32'(start));
		cpu_read({1'b0, 2'b01, 2'b00, rom_base[0]});
		cpu_idle();
		apb_access(1'b0, REG_ROM_DATA, 32'h0, 1'b0, rd);
		check("ROM_DATA read", rd, 32'h0);
		// bad offsets
		apb_access(1'b0, 12'h010, 32'h0, 1'b1, rd);
		apb_access(1'b1, 12'h024, 32'h1, 1'b1, rd);
		apb_access(1'b0, REG_CTRL, 32'h0, 1'b0, rd);
		check("CTRL after bad write", rd, 32'h0);

		// ram banks
		for (int b = 0; b < RAM_BANKS; b++) begin
			for (int i = 0; i < RAM_N; i++) begin
				r = rand_word();
				a = {1'b1, 1'b0, 3'(b), r[13:0]};
				cpu_write(a, r[21:14]);
				ram_list.push_back(a);
			end
		end
		foreach (ram_list[k]) begin
			cpu_read(ram_list[k]);
		end
		cpu_idle();

		// empty space writes aimed at offsets already holding ram data
		pick = 0;
		for (int c = 0; c < 16; c++) begin
			cd = 4'(c);
			if (rom_bank_of(cd[3:2], cd[1:0]) < 0) begin
				a = ram_list[pick];
				cpu_write({1'b0, cd, a[13:0]}, ~ram_sh[a[16:0]]);
				pick = (pick + 1) % RAM_N;
			end
		end
		// upper ram space, same bank and offset bits as stored bytes
		for (int i = 0; i < 8; i++) begin
			a = ram_list[i];
			cpu_write({2'b11, a[16:0]}, ~ram_sh[a[16:0]]);
			cpu_read({2'b11, a[16:0]});
			cpu_idle();
		end
		// ram untouched
		foreach (ram_list[k]) begin
			cpu_read(ram_list[k]);
		end
		cpu_idle();

		// tape slicer, random levels with idle gaps
		for (int n = 0; n < 200; n++) begin
			r = rand_word();
			smp = r[11:0];
			@(posedge clk_sys);
			#2;
			adc_in.valid = 1'b1;
			adc_in.sample = smp;
			exp_st = slicer_ref(smp);
			@(posedge clk_sys);
			#2;
			adc_in.valid = 1'b0;
			@(negedge clk_sys);
			check("o_tape_bit", 32'(tape_bit), 32'(exp_st[12]));
			apb_access(1'b0, REG_STATUS, 32'h0, 1'b0, rd);
			check("STATUS", rd, 32'(exp_st));
			repeat (r[13:12]) @(posedge clk_sys);
		end

		repeat (2) @(posedge clk_sys);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
